//--- rtl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  localparam int word_w     = 32;
  localparam int reg_addr_w = 5;

  typedef logic [word_w-1:0]     word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  localparam reg_addr_t reg_zero = '0;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    op_rtype = 6'b000000,
    op_lw    = 6'b100011,
    op_sw    = 6'b101011,
    op_addi  = 6'b001000,
    op_addiu = 6'b001001,
    op_slti  = 6'b001010,
    op_sltiu = 6'b001011,
    op_ori   = 6'b001101,
    op_lui   = 6'b001111
  } opcode_e;

  // r-type function field, instr[5:0]
  typedef enum logic [5:0] {
    fn_add  = 6'b100000,
    fn_addu = 6'b100001,
    fn_sub  = 6'b100010,
    fn_subu = 6'b100011,
    fn_and  = 6'b100100,
    fn_or   = 6'b100101,
    fn_slt  = 6'b101010,
    fn_sltu = 6'b101011
  } funct_e;

  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_e;

  // how the 16-bit immediate becomes a word
  typedef enum logic [1:0] {
    imm_sign  = 2'b00,
    imm_zero  = 2'b01,
    imm_upper = 2'b10
  } imm_kind_e;

endpackage

`default_nettype wire

//--- rtl/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

  // decoded controls for one instruction
  typedef struct packed {
    logic                    reg_write;
    logic                    mem_to_reg;
    logic                    mem_write;
    logic                    alu_src;
    logic                    reg_dst;
    mips_isa_pkg::imm_kind_e imm_kind;
    mips_isa_pkg::alu_op_e   alu_op;
  } ctrl_t;

  // ------------------------------
  // pipeline registers
  // ------------------------------
  typedef struct packed {
    ctrl_t                   ctrl;
    mips_isa_pkg::word_t     rs_val;
    mips_isa_pkg::word_t     rt_val;
    mips_isa_pkg::word_t     imm;
    mips_isa_pkg::reg_addr_t rs;
    mips_isa_pkg::reg_addr_t rt;
    mips_isa_pkg::reg_addr_t dest;
  } id_ex_t;

  typedef struct packed {
    logic                    reg_write;
    logic                    mem_to_reg;
    logic                    mem_write;
    mips_isa_pkg::word_t     alu_result;
    mips_isa_pkg::word_t     store_data;
    mips_isa_pkg::reg_addr_t dest;
  } ex_mem_t;

  typedef struct packed {
    logic                    reg_write;
    logic                    mem_to_reg;
    mips_isa_pkg::word_t     alu_result;
    mips_isa_pkg::word_t     load_data;
    mips_isa_pkg::reg_addr_t dest;
  } mem_wb_t;

  // operand source in execute
  typedef enum logic [1:0] {
    fwd_none = 2'b00,
    fwd_wb   = 2'b01,
    fwd_mem  = 2'b10
  } fwd_sel_e;

  typedef struct packed {
    logic                write;
    mips_isa_pkg::word_t addr;
    mips_isa_pkg::word_t wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

//--- rtl/mips_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decoder (
  input  wire mips_isa_pkg::opcode_e opcode,
  input  wire mips_isa_pkg::funct_e  funct,
  output mips_pipe_pkg::ctrl_t       ctrl
);

  always_comb
  begin
    // anything not matched below stays a no-op
    ctrl = '0;
    case (opcode)
      mips_isa_pkg::op_rtype:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = 1'b1;
        case (funct)
          mips_isa_pkg::fn_add, mips_isa_pkg::fn_addu: ctrl.alu_op = mips_isa_pkg::alu_add;
          mips_isa_pkg::fn_sub, mips_isa_pkg::fn_subu: ctrl.alu_op = mips_isa_pkg::alu_sub;
          mips_isa_pkg::fn_and:                        ctrl.alu_op = mips_isa_pkg::alu_and;
          mips_isa_pkg::fn_or:                         ctrl.alu_op = mips_isa_pkg::alu_or;
          mips_isa_pkg::fn_slt, mips_isa_pkg::fn_sltu: ctrl.alu_op = mips_isa_pkg::alu_slt;
          default:                                     ctrl = '0;
        endcase
      end
      mips_isa_pkg::op_lw:
      begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.alu_op     = mips_isa_pkg::alu_add;
      end
      mips_isa_pkg::op_sw:
      begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = mips_isa_pkg::alu_add;
      end
      // no overflow trap, so addi and addiu behave the same
      mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = mips_isa_pkg::alu_add;
      end
      mips_isa_pkg::op_slti, mips_isa_pkg::op_sltiu:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = mips_isa_pkg::alu_slt;
      end
      mips_isa_pkg::op_ori:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.imm_kind  = mips_isa_pkg::imm_zero;
        ctrl.alu_op    = mips_isa_pkg::alu_or;
      end
      // rs field is r0 for lui, so or with it passes the shifted value
      mips_isa_pkg::op_lui:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.imm_kind  = mips_isa_pkg::imm_upper;
        ctrl.alu_op    = mips_isa_pkg::alu_or;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire mips_isa_pkg::reg_addr_t ra1,
  input  wire mips_isa_pkg::reg_addr_t ra2,
  output mips_isa_pkg::word_t          rd1,
  output mips_isa_pkg::word_t          rd2,
  input  wire                          we,
  input  wire mips_isa_pkg::reg_addr_t wa,
  input  wire mips_isa_pkg::word_t     wd
);

  mips_isa_pkg::word_t regs [32];
  logic                wr_live;

  // r0 is never written, so it reads as zero
  assign wr_live = we && (wa != mips_isa_pkg::reg_zero);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_live)
    begin
      regs[wa] <= wd;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

//--- rtl/mips_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mips_hazard_unit (
  input  wire mips_isa_pkg::reg_addr_t id_rs,
  input  wire mips_isa_pkg::reg_addr_t id_rt,
  input  wire mips_pipe_pkg::id_ex_t   id_ex,
  input  wire mips_pipe_pkg::ex_mem_t  ex_mem,
  input  wire mips_pipe_pkg::mem_wb_t  mem_wb,
  output mips_pipe_pkg::fwd_sel_e      fwd_a,
  output mips_pipe_pkg::fwd_sel_e      fwd_b,
  output logic                         stall
);

  // memory stage wins over writeback and r0 never forwards
  function automatic mips_pipe_pkg::fwd_sel_e pick_source(
    input mips_isa_pkg::reg_addr_t src,
    input mips_pipe_pkg::ex_mem_t  mem_st,
    input mips_pipe_pkg::mem_wb_t  wb_st
  );
    mips_pipe_pkg::fwd_sel_e sel;
    sel = mips_pipe_pkg::fwd_none;
    if (src != mips_isa_pkg::reg_zero)
    begin
      if (mem_st.reg_write && mem_st.dest == src)
      begin
        sel = mips_pipe_pkg::fwd_mem;
      end
      else if (wb_st.reg_write && wb_st.dest == src)
      begin
        sel = mips_pipe_pkg::fwd_wb;
      end
    end
    return sel;
  endfunction

  always_comb
  begin
    fwd_a = pick_source(id_ex.rs, ex_mem, mem_wb);
    fwd_b = pick_source(id_ex.rt, ex_mem, mem_wb);
  end

  // ------------------------------
  // load-use
  // ------------------------------
  // load result only exists after memory so decode holds one cycle
  assign stall = id_ex.ctrl.mem_to_reg &&
                 (id_ex.dest != mips_isa_pkg::reg_zero) &&
                 ((id_ex.dest == id_rs) || (id_ex.dest == id_rt));

endmodule

`default_nettype wire

//--- rtl/mips_execute.sv
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
  input  wire mips_pipe_pkg::id_ex_t   id_ex,
  input  wire mips_pipe_pkg::fwd_sel_e fwd_a,
  input  wire mips_pipe_pkg::fwd_sel_e fwd_b,
  input  wire mips_isa_pkg::word_t     mem_result,
  input  wire mips_isa_pkg::word_t     wb_result,
  output mips_isa_pkg::word_t          alu_result,
  output mips_isa_pkg::word_t          store_data
);

  mips_isa_pkg::word_t src_a;
  mips_isa_pkg::word_t src_b;
  mips_isa_pkg::word_t fwd_b_val;

  function automatic mips_isa_pkg::word_t operand(
    input mips_pipe_pkg::fwd_sel_e sel,
    input mips_isa_pkg::word_t     reg_val,
    input mips_isa_pkg::word_t     mem_val,
    input mips_isa_pkg::word_t     wb_val
  );
    case (sel)
      mips_pipe_pkg::fwd_mem: return mem_val;
      mips_pipe_pkg::fwd_wb:  return wb_val;
      default:                return reg_val;
    endcase
  endfunction

  // ------------------------------
  // operand select
  // ------------------------------
  assign src_a     = operand(fwd_a, id_ex.rs_val, mem_result, wb_result);
  assign fwd_b_val = operand(fwd_b, id_ex.rt_val, mem_result, wb_result);
  assign src_b     = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b_val;

  // stores write the forwarded rt
  assign store_data = fwd_b_val;

  always_comb
  begin
    case (id_ex.ctrl.alu_op)
      mips_isa_pkg::alu_and: alu_result = src_a & src_b;
      mips_isa_pkg::alu_or:  alu_result = src_a | src_b;
      mips_isa_pkg::alu_add: alu_result = src_a + src_b;
      mips_isa_pkg::alu_sub: alu_result = src_a - src_b;
      mips_isa_pkg::alu_slt: alu_result = {31'd0, $signed(src_a) < $signed(src_b)};
      default:               alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
  parameter mips_isa_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  wire                      clk,
  input  wire                      rst_n,
  output mips_isa_pkg::word_t      pc,
  input  wire mips_isa_pkg::word_t instr,
  output mips_pipe_pkg::dmem_req_t dmem,
  input  wire mips_isa_pkg::word_t dmem_rdata
);

  mips_isa_pkg::word_t     if_id_instr;
  mips_isa_pkg::reg_addr_t id_rs;
  mips_isa_pkg::reg_addr_t id_rt;
  mips_isa_pkg::reg_addr_t id_rd;
  mips_pipe_pkg::ctrl_t    id_ctrl;
  mips_isa_pkg::word_t     id_rs_val;
  mips_isa_pkg::word_t     id_rt_val;
  mips_isa_pkg::word_t     id_imm;
  mips_pipe_pkg::id_ex_t   id_ex_d;
  mips_pipe_pkg::id_ex_t   id_ex;
  mips_pipe_pkg::ex_mem_t  ex_mem;
  mips_pipe_pkg::mem_wb_t  mem_wb;
  mips_pipe_pkg::fwd_sel_e fwd_a;
  mips_pipe_pkg::fwd_sel_e fwd_b;
  mips_isa_pkg::word_t     ex_alu_result;
  mips_isa_pkg::word_t     ex_store_data;
  mips_isa_pkg::word_t     wb_result;
  logic                    stall;

  // ------------------------------
  // fetch
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc          <= reset_pc;
      if_id_instr <= '0;
    end
    else if (!stall)
    begin
      pc          <= pc + 32'd4;
      if_id_instr <= instr;
    end
  end

  // ------------------------------
  // decode
  // ------------------------------
  assign id_rs = if_id_instr[25:21];
  assign id_rt = if_id_instr[20:16];
  assign id_rd = if_id_instr[15:11];

  mips_decoder u_decoder (
    .opcode (mips_isa_pkg::opcode_e'(if_id_instr[31:26])),
    .funct  (mips_isa_pkg::funct_e'(if_id_instr[5:0])),
    .ctrl   (id_ctrl)
  );

  mips_regfile u_regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .ra1   (id_rs),
    .ra2   (id_rt),
    .rd1   (id_rs_val),
    .rd2   (id_rt_val),
    .we    (mem_wb.reg_write),
    .wa    (mem_wb.dest),
    .wd    (wb_result)
  );

  always_comb
  begin
    case (id_ctrl.imm_kind)
      mips_isa_pkg::imm_zero:  id_imm = {16'h0000, if_id_instr[15:0]};
      mips_isa_pkg::imm_upper: id_imm = {if_id_instr[15:0], 16'h0000};
      default:                 id_imm = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
    endcase
  end

  always_comb
  begin
    id_ex_d.ctrl   = id_ctrl;
    id_ex_d.rs_val = id_rs_val;
    id_ex_d.rt_val = id_rt_val;
    id_ex_d.imm    = id_imm;
    id_ex_d.rs     = id_rs;
    id_ex_d.rt     = id_rt;
    id_ex_d.dest   = id_ctrl.reg_dst ? id_rd : id_rt;
    // bubble into execute while decode waits on a load
    if (stall)
    begin
      id_ex_d.ctrl = '0;
    end
  end

  mips_hazard_unit u_hazard (
    .id_rs  (id_rs),
    .id_rt  (id_rt),
    .id_ex  (id_ex),
    .ex_mem (ex_mem),
    .mem_wb (mem_wb),
    .fwd_a  (fwd_a),
    .fwd_b  (fwd_b),
    .stall  (stall)
  );

  // ------------------------------
  // execute
  // ------------------------------
  mips_execute u_execute (
    .id_ex      (id_ex),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_result (ex_mem.alu_result),
    .wb_result  (wb_result),
    .alu_result (ex_alu_result),
    .store_data (ex_store_data)
  );

  // pipeline registers behind decode
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end
    else
    begin
      id_ex             <= id_ex_d;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.alu_result <= ex_alu_result;
      ex_mem.store_data <= ex_store_data;
      ex_mem.dest       <= id_ex.dest;
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= dmem_rdata;
      mem_wb.dest       <= ex_mem.dest;
    end
  end

  // memory port straight from ex/mem
  assign dmem.write = ex_mem.mem_write;
  assign dmem.addr  = ex_mem.alu_result;
  assign dmem.wdata = ex_mem.store_data;

  assign wb_result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

//--- test/mips_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_properties (
  input wire                           clk,
  input wire                           rst_n,
  input wire mips_isa_pkg::word_t      pc,
  input wire mips_pipe_pkg::dmem_req_t dmem,
  input wire                           stall
);

  // ------------------------------
  // pipeline hold
  // ------------------------------
  // the bubble clears the load from execute
  stall_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> !stall)
    else $error("stall high for two cycles in a row");

  pc_holds_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> $stable(pc))
    else $error("pc moved while stall was high");

  // memory port quiet in reset
  no_write_in_reset: assert property (@(posedge clk)
    !rst_n |-> !dmem.write)
    else $error("dmem write high during reset");

endmodule

bind mips_core mips_core_properties u_properties (
  .clk   (clk),
  .rst_n (rst_n),
  .pc    (pc),
  .dmem  (dmem),
  .stall (stall)
);

`default_nettype wire

//--- test/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

  localparam int n_cases     = 6;
  localparam int max_words   = 12;
  localparam int max_stores  = 6;
  localparam int clk_period  = 20;
  localparam int reset_len   = 10;
  localparam int run_limit   = 40;
  localparam int watchdog_ns = n_cases * 60 * clk_period;

  logic                     clk;
  logic                     rst_n;
  mips_isa_pkg::word_t      pc;
  mips_isa_pkg::word_t      instr;
  mips_pipe_pkg::dmem_req_t dmem_req;
  mips_isa_pkg::word_t      dmem_rdata;

  mips_isa_pkg::word_t imem [64];
  mips_isa_pkg::word_t data_mem [64];
  mips_isa_pkg::word_t store_addr_q [$];
  mips_isa_pkg::word_t store_data_q [$];

  // case table
  string               case_name [n_cases];
  mips_isa_pkg::word_t prog [n_cases][max_words];
  int                  n_stores [n_cases];
  mips_isa_pkg::word_t exp_addr [n_cases][max_stores];
  mips_isa_pkg::word_t exp_data [n_cases][max_stores];
  int                  exp_first [n_cases];
  logic                exp_hold [n_cases];

  mips_core #(
    .reset_pc (32'h0000_0000)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .instr      (instr),
    .dmem       (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ------------------------------
  // memory models
  // ------------------------------
  assign instr      = imem[pc[7:2]];
  assign dmem_rdata = rst_n ? data_mem[dmem_req.addr[7:2]] : '0;

  // each word preloaded in reset with its own byte address
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 64; i++)
      begin
        data_mem[i] <= 32'hcafe_0000 + (i * 4);
      end
      store_addr_q.delete();
      store_data_q.delete();
    end
    else if (dmem_req.write)
    begin
      data_mem[dmem_req.addr[7:2]] <= dmem_req.wdata;
      store_addr_q.push_back(dmem_req.addr);
      store_data_q.push_back(dmem_req.wdata);
    end
  end

  // ------------------------------
  // encoders and checks
  // ------------------------------
  function automatic mips_isa_pkg::word_t rtype_word(input mips_isa_pkg::funct_e fn,
      input mips_isa_pkg::reg_addr_t rd, input mips_isa_pkg::reg_addr_t rs,
      input mips_isa_pkg::reg_addr_t rt);
    return {mips_isa_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
  endfunction

  // operand order as in "addi rt, rs, imm" and "sw rt, imm(rs)"
  function automatic mips_isa_pkg::word_t itype_word(input mips_isa_pkg::opcode_e op,
      input mips_isa_pkg::reg_addr_t rt, input mips_isa_pkg::reg_addr_t rs,
      input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic abort_run;
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input mips_isa_pkg::word_t exp,
      input mips_isa_pkg::word_t act);
    if (exp !== act)
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_stall(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic add_store(input int c, input int k, input mips_isa_pkg::word_t addr,
      input mips_isa_pkg::word_t data);
    exp_addr[c][k] = addr;
    exp_data[c][k] = data;
    n_stores[c]    = k + 1;
  endtask

  task automatic fill_table;
    for (int c = 0; c < n_cases; c++)
    begin
      for (int w = 0; w < max_words; w++)
      begin
        prog[c][w] = '0;
      end
      exp_hold[c] = 1'b0;
    end
    case_name[0] = "reset_state";
    prog[0][0] = itype_word(mips_isa_pkg::op_addi, 5'd1, 5'd0, 16'h0055);
    prog[0][1] = itype_word(mips_isa_pkg::op_sw, 5'd1, 5'd0, 16'h0010);
    add_store(0, 0, 32'h10, 32'h55);
    exp_first[0] = 4;
    // dependent chain with each result straight into the next
    case_name[1] = "rtype_forward";
    prog[1][0]  = itype_word(mips_isa_pkg::op_addi, 5'd1, 5'd0, 16'h0007);
    prog[1][1]  = itype_word(mips_isa_pkg::op_addi, 5'd2, 5'd0, 16'hfffd);
    prog[1][2]  = rtype_word(mips_isa_pkg::fn_add, 5'd3, 5'd1, 5'd2);
    prog[1][3]  = rtype_word(mips_isa_pkg::fn_sub, 5'd4, 5'd3, 5'd1);
    prog[1][4]  = rtype_word(mips_isa_pkg::fn_and, 5'd5, 5'd4, 5'd1);
    prog[1][5]  = rtype_word(mips_isa_pkg::fn_or, 5'd6, 5'd5, 5'd2);
    prog[1][6]  = rtype_word(mips_isa_pkg::fn_slt, 5'd7, 5'd4, 5'd1);
    for (int k = 0; k < 5; k++)
    begin
      prog[1][7 + k] = itype_word(mips_isa_pkg::op_sw, 5'(3 + k), 5'd0, 16'(4 * k));
    end
    add_store(1, 0, 32'h00, 32'h0000_0004);
    add_store(1, 1, 32'h04, 32'hffff_fffd);
    add_store(1, 2, 32'h08, 32'h0000_0005);
    add_store(1, 3, 32'h0c, 32'hffff_fffd);
    add_store(1, 4, 32'h10, 32'h0000_0001);
    exp_first[1] = 10;
    case_name[2] = "immediates";
    prog[2][0] = itype_word(mips_isa_pkg::op_addi, 5'd1, 5'd0, 16'hff80);
    prog[2][1] = itype_word(mips_isa_pkg::op_ori, 5'd2, 5'd0, 16'h8001);
    prog[2][2] = itype_word(mips_isa_pkg::op_lui, 5'd3, 5'd0, 16'h1234);
    prog[2][3] = itype_word(mips_isa_pkg::op_ori, 5'd3, 5'd3, 16'h5678);
    prog[2][4] = itype_word(mips_isa_pkg::op_sw, 5'd1, 5'd0, 16'h0020);
    prog[2][5] = itype_word(mips_isa_pkg::op_sw, 5'd2, 5'd0, 16'h0024);
    prog[2][6] = itype_word(mips_isa_pkg::op_sw, 5'd3, 5'd0, 16'h0028);
    add_store(2, 0, 32'h20, 32'hffff_ff80);
    add_store(2, 1, 32'h24, 32'h0000_8001);
    add_store(2, 2, 32'h28, 32'h1234_5678);
    exp_first[2] = 7;
    // base 0x100 minus 0xc0 reaches word 0x40
    case_name[3] = "load_use";
    prog[3][0] = itype_word(mips_isa_pkg::op_addi, 5'd1, 5'd0, 16'h0100);
    prog[3][1] = itype_word(mips_isa_pkg::op_lw, 5'd2, 5'd1, 16'hff40);
    prog[3][2] = rtype_word(mips_isa_pkg::fn_add, 5'd3, 5'd2, 5'd1);
    prog[3][3] = itype_word(mips_isa_pkg::op_sw, 5'd3, 5'd0, 16'h0030);
    add_store(3, 0, 32'h30, 32'hcafe_0140);
    exp_first[3] = 7;
    exp_hold[3]  = 1'b1;
    case_name[4] = "reg_zero";
    prog[4][0] = itype_word(mips_isa_pkg::op_addi, 5'd2, 5'd0, 16'h0123);
    prog[4][1] = itype_word(mips_isa_pkg::op_addi, 5'd0, 5'd0, 16'h0077);
    prog[4][2] = rtype_word(mips_isa_pkg::fn_add, 5'd4, 5'd0, 5'd2);
    prog[4][3] = itype_word(mips_isa_pkg::op_sw, 5'd4, 5'd0, 16'h0034);
    prog[4][4] = itype_word(mips_isa_pkg::op_sw, 5'd0, 5'd0, 16'h0038);
    add_store(4, 0, 32'h34, 32'h0000_0123);
    add_store(4, 1, 32'h38, 32'h0000_0000);
    exp_first[4] = 6;
    case_name[5] = "load_store_copy";
    prog[5][0] = itype_word(mips_isa_pkg::op_lw, 5'd5, 5'd0, 16'h0008);
    prog[5][1] = itype_word(mips_isa_pkg::op_sw, 5'd5, 5'd0, 16'h003c);
    add_store(5, 0, 32'h3c, 32'hcafe_0008);
    exp_first[5] = 5;
    exp_hold[5]  = 1'b1;
  endtask

  // ------------------------------
  // one program from reset to its last store
  // ------------------------------
  task automatic run_case(input int c);
    int                  cycles;
    int                  holds;
    int                  first_cycle;
    mips_isa_pkg::word_t prev_pc;
    cycles      = 0;
    holds       = 0;
    first_cycle = -1;
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < 64; i++)
    begin
      imem[i] = (i < max_words) ? prog[c][i] : '0;
    end
    repeat (reset_len) @(posedge clk);
    check_word({case_name[c], " write in reset"}, '0,
        mips_isa_pkg::word_t'(dmem_req.write));
    rst_n <= 1'b1;
    @(negedge clk);
    check_word({case_name[c], " pc after reset"}, 32'h0000_0000, pc);
    prev_pc = pc;
    while (store_addr_q.size() < n_stores[c] && cycles < run_limit)
    begin
      @(negedge clk);
      cycles++;
      if (pc == prev_pc)
      begin
        holds++;
      end
      prev_pc = pc;
      if (dmem_req.write && first_cycle < 0)
      begin
        first_cycle = cycles;
      end
    end
    if (store_addr_q.size() < n_stores[c])
    begin
      $display("%s: only %0d of %0d stores seen within %0d cycles", case_name[c],
          store_addr_q.size(), n_stores[c], run_limit);
      abort_run();
    end
    for (int k = 0; k < n_stores[c]; k++)
    begin
      check_word({case_name[c], " store address"}, exp_addr[c][k], store_addr_q[k]);
      check_word({case_name[c], " store data"}, exp_data[c][k], store_data_q[k]);
    end
    check_word({case_name[c], " first store cycle"}, mips_isa_pkg::word_t'(exp_first[c]),
        mips_isa_pkg::word_t'(first_cycle));
    if (holds > 1)
    begin
      $display("%s: pc held for %0d cycles instead of at most one", case_name[c], holds);
      abort_run();
    end
    check_stall({case_name[c], " load-use hold"}, exp_hold[c], holds != 0);
  endtask

  initial
  begin
    rst_n = 1'b0;
    for (int i = 0; i < 64; i++)
    begin
      imem[i] = '0;
    end
    fill_table();
    for (int c = 0; c < n_cases; c++)
    begin
      run_case(c);
    end
    $display("=== PASS ===");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired before all cases finished");
    abort_run();
  end

endmodule

`default_nettype wire

//--- all.f
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/mips_decoder.sv
rtl/mips_regfile.sv
rtl/mips_hazard_unit.sv
rtl/mips_execute.sv
rtl/mips_core.sv
test/mips_core_properties.sv
test/tb_mips_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BINARY)
	$(BINARY) | tee /dev/stderr | grep -qx -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
